// ==== tb.f ====
+incdir+logic
logic/bridge_pkg.sv
logic/bridge_ifs.sv
logic/req_capture.sv
logic/beat_sequencer.sv
logic/resp_assemble.sv
logic/wb64_to_wb32_bridge.sv
logic/dual_bridge_top.sv
dv/bridge_asserts.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the dual bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f tb.f --top-module tb_top -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "run.sh: simulation ok"
else
    echo "run.sh: simulation reported failure"
    exit 1
fi

// ==== dv/tb_top.sv ====
`default_nettype none

module tb_top;

    localparam int NUM_TXN     = 300;  // per port
    localparam int ACK_TIMEOUT = 100;  // cycles
    localparam int MAX_WAIT    = 3;    // memory wait states
    localparam bridge_pkg::wide_addr_t WIN_BASE = 29'h0ace_5670;

    typedef struct packed {
        logic                     we;
        bridge_pkg::narrow_sel_t  sel;
        bridge_pkg::narrow_addr_t addr;
        bridge_pkg::narrow_data_t data;
    } beat_t;

    logic clk;
    logic rst;

    // index 0 is the instruction port, 1 the data port
    logic [1:0]                    w_cyc;
    logic [1:0]                    w_stb;
    logic [1:0]                    w_we;
    bridge_pkg::wide_addr_t        w_adr [2];
    bridge_pkg::wide_data_t        w_wdata [2];
    bridge_pkg::wide_sel_t         w_sel [2];
    wire bridge_pkg::wide_data_t   w_rdata [2];
    wire [1:0]                     w_ack;
    wire [1:0]                     n_cyc;
    wire [1:0]                     n_stb;
    wire [1:0]                     n_we;
    wire bridge_pkg::narrow_addr_t n_addr [2];
    wire bridge_pkg::narrow_data_t n_wdata [2];
    wire bridge_pkg::narrow_sel_t  n_sel [2];
    logic [1:0]                    n_ack;
    bridge_pkg::narrow_data_t      n_rdata [2];

    bridge_pkg::narrow_data_t mem_words [2][bridge_pkg::narrow_addr_t]; // key is word address
    bridge_pkg::wide_data_t   ref_words [2][bridge_pkg::wide_addr_t];
    beat_t                    beat_q [2][$];  // narrow beats still expected

    dual_bridge_top dual_bridge_top_i (
        .clk        (clk),
        .rst        (rst),
        .i_cyc_i    (w_cyc[0]),
        .i_stb_i    (w_stb[0]),
        .i_we_i     (w_we[0]),
        .i_adr_i    (w_adr[0]),
        .i_dat_i    (w_wdata[0]),
        .i_sel_i    (w_sel[0]),
        .i_dat_o    (w_rdata[0]),
        .i_ack_o    (w_ack[0]),
        .i_n_cyc_o  (n_cyc[0]),
        .i_n_stb_o  (n_stb[0]),
        .i_n_we_o   (n_we[0]),
        .i_n_addr_o (n_addr[0]),
        .i_n_dat_o  (n_wdata[0]),
        .i_n_dat_i  (n_rdata[0]),
        .i_n_sel_o  (n_sel[0]),
        .i_n_ack_i  (n_ack[0]),
        .d_cyc_i    (w_cyc[1]),
        .d_stb_i    (w_stb[1]),
        .d_we_i     (w_we[1]),
        .d_adr_i    (w_adr[1]),
        .d_dat_i    (w_wdata[1]),
        .d_sel_i    (w_sel[1]),
        .d_dat_o    (w_rdata[1]),
        .d_ack_o    (w_ack[1]),
        .d_n_cyc_o  (n_cyc[1]),
        .d_n_stb_o  (n_stb[1]),
        .d_n_we_o   (n_we[1]),
        .d_n_addr_o (n_addr[1]),
        .d_n_dat_o  (n_wdata[1]),
        .d_n_dat_i  (n_rdata[1]),
        .d_n_sel_o  (n_sel[1]),
        .d_n_ack_i  (n_ack[1])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, want);
            abort_run();
        end
    endtask

    // initial memory contents, per port and word address
    function automatic bridge_pkg::narrow_data_t fill_word(input int p,
                                                           input bridge_pkg::narrow_addr_t w);
        return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ ((p == 0) ? 32'h0 : 32'h5a5a_a5a5);
    endfunction

    function automatic bridge_pkg::narrow_data_t mem_read(input int p,
                                                          input bridge_pkg::narrow_addr_t w);
        return mem_words[p].exists(w) ? mem_words[p][w] : fill_word(p, w);
    endfunction

    // wide word idx spans narrow words 2*idx (low) and 2*idx+1 (high)
    function automatic bridge_pkg::wide_data_t ref_read(input int p,
                                                        input bridge_pkg::wide_addr_t idx);
        bridge_pkg::narrow_addr_t w;
        w = bridge_pkg::narrow_addr_t'({idx, 1'b0});
        if (ref_words[p].exists(idx)) begin
            return ref_words[p][idx];
        end
        return {fill_word(p, w + 32'd1), fill_word(p, w)};
    endfunction

    function automatic void write_ref(input int p, input bridge_pkg::wide_addr_t idx,
                                      input bridge_pkg::wide_sel_t sel,
                                      input bridge_pkg::wide_data_t d);
        bridge_pkg::wide_data_t word;
        word = ref_read(p, idx);
        for (int b = 0; b < 8; b++) begin
            if (sel[b]) begin
                word[8*b +: 8] = d[8*b +: 8];
            end
        end
        ref_words[p][idx] = word;
    endfunction

    function automatic bridge_pkg::wide_sel_t pick_sel();
        bridge_pkg::wide_sel_t sel;
        case ($urandom_range(0, 4))
            0:       sel = 8'h00;
            1:       sel = 8'h0f;
            2:       sel = 8'hf0;
            3:       sel = 8'hff;
            default: sel = bridge_pkg::wide_sel_t'($urandom());
        endcase
        return sel;
    endfunction

    // 32-bit memory behind one narrow port
    task automatic serve_memory(input int p);
        int                       wait_left;
        logic                     in_beat;
        beat_t                    want;
        bridge_pkg::narrow_data_t word;
        bridge_pkg::narrow_addr_t w;
        in_beat   = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge clk);
            n_ack[p] = 1'b0;
            if (n_stb[p] === 1'b1) begin
                if (!in_beat) begin
                    if (beat_q[p].size() == 0) begin
                        $display("port %0d: unexpected narrow beat at 0x%h", p, n_addr[p]);
                        abort_run();
                    end
                    want = beat_q[p].pop_front();
                    check_value($sformatf("port%0d n_we", p), 64'(n_we[p]), 64'(want.we));
                    check_value($sformatf("port%0d n_addr", p), 64'(n_addr[p]), 64'(want.addr));
                    check_value($sformatf("port%0d n_sel", p), 64'(n_sel[p]), 64'(want.sel));
                    if (want.we) begin
                        check_value($sformatf("port%0d n_dat_o", p), 64'(n_wdata[p]),
                                    64'(want.data));
                    end
                    in_beat   = 1'b1;
                    wait_left = int'($urandom_range(0, MAX_WAIT));
                end
                if (wait_left == 0) begin
                    w    = n_addr[p] >> 2;
                    word = mem_read(p, w);
                    if (n_we[p]) begin
                        for (int b = 0; b < 4; b++) begin
                            if (n_sel[p][b]) begin
                                word[8*b +: 8] = n_wdata[p][8*b +: 8];
                            end
                        end
                        mem_words[p][w] = word;
                    end else begin
                        n_rdata[p] = word;
                    end
                    n_ack[p] = 1'b1;
                    in_beat  = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    endtask

    // random wide master on one port
    task automatic run_master(input int p);
        int                       t;
        logic                     we;
        bridge_pkg::wide_addr_t   idx;
        bridge_pkg::wide_sel_t    sel;
        bridge_pkg::wide_data_t   wdata;
        bridge_pkg::wide_data_t   model;
        bridge_pkg::wide_data_t   expect_rd;
        bridge_pkg::narrow_addr_t base;
        for (int n = 0; n < NUM_TXN; n++) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
            we    = 1'($urandom_range(0, 1));
            idx   = WIN_BASE + bridge_pkg::wide_addr_t'($urandom_range(0, 7));
            sel   = pick_sel();
            wdata = {$urandom(), $urandom()};
            base  = {idx, 3'b000};  // byte address of the low beat
            model = ref_read(p, idx);
            expect_rd = '0;
            if (|sel[3:0]) begin
                beat_q[p].push_back({we, sel[3:0], base, wdata[31:0]});
                expect_rd[31:0] = we ? 32'h0 : model[31:0];
            end
            if (|sel[7:4]) begin
                beat_q[p].push_back({we, sel[7:4], base + 32'd4, wdata[63:32]});
                expect_rd[63:32] = we ? 32'h0 : model[63:32];
            end
            w_we[p]    = we;
            w_adr[p]   = idx;
            w_wdata[p] = wdata;
            w_sel[p]   = sel;
            w_cyc[p]   = 1'b1;
            w_stb[p]   = 1'b1;
            t = 0;
            @(negedge clk);
            while (w_ack[p] !== 1'b1) begin
                if (t == ACK_TIMEOUT) begin
                    $display("port %0d: wide ack never came within %0d cycles", p, t);
                    abort_run();
                end
                t++;
                @(negedge clk);
            end
            check_value($sformatf("port%0d dat_o", p), w_rdata[p], expect_rd);
            check_value($sformatf("port%0d beats left", p), 64'(beat_q[p].size()), 64'h0);
            w_cyc[p] = 1'b0;
            w_stb[p] = 1'b0;
            if (we) begin
                write_ref(p, idx, sel, wdata);
            end
            @(negedge clk);
            check_value($sformatf("port%0d ack_o", p), 64'(w_ack[p]), 64'h0); // single cycle
        end
    endtask

    initial begin
        rst   = 1'b1;
        w_cyc = '0;
        w_stb = '0;
        w_we  = '0;
        n_ack = '0;
        for (int p = 0; p < 2; p++) begin
            w_adr[p]   = '0;
            w_wdata[p] = '0;
            w_sel[p]   = '0;
            n_rdata[p] = '0;
        end
        void'($urandom(13));
        // both bridges stay quiet through reset and before the first request
        for (int c = 0; c < 18; c++) begin
            @(negedge clk);
            if (c == 15) begin
                rst = 1'b0;
            end
            check_value("n_cyc", 64'(n_cyc), 64'h0);
            check_value("n_stb", 64'(n_stb), 64'h0);
            check_value("wide ack", 64'(w_ack), 64'h0);
        end
        fork
            serve_memory(0);
            serve_memory(1);
        join_none
        fork
            run_master(0);
            run_master(1);
        join
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/bridge_asserts.sv ====
`default_nettype none

module bridge_asserts (
    input wire logic                     clk,
    input wire logic                     rst,
    input wire logic                     ack_o,
    input wire logic                     n_cyc_o,
    input wire logic                     n_stb_o,
    input wire bridge_pkg::narrow_addr_t n_addr_o,
    input wire bridge_pkg::narrow_data_t n_dat_o,
    input wire bridge_pkg::narrow_sel_t  n_sel_o,
    input wire logic                     n_ack_i
);

    stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        n_stb_o |-> n_cyc_o)
        else $error("narrow stb high without cyc");

    // a stalled beat holds its request
    beat_held: assert property (@(posedge clk) disable iff (rst)
        (n_stb_o && !n_ack_i) |=> (n_stb_o && $stable(n_addr_o) && $stable(n_sel_o)
                                   && $stable(n_dat_o)))
        else $error("narrow request changed before ack");

    wide_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        ack_o |=> !ack_o)
        else $error("wide ack longer than one cycle");

    sel_live: assert property (@(posedge clk) disable iff (rst)
        n_stb_o |-> (n_sel_o != '0))
        else $error("narrow beat issued with no byte selects");

endmodule

bind wb64_to_wb32_bridge bridge_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .ack_o    (ack_o),
    .n_cyc_o  (n_cyc_o),
    .n_stb_o  (n_stb_o),
    .n_addr_o (n_addr_o),
    .n_dat_o  (n_dat_o),
    .n_sel_o  (n_sel_o),
    .n_ack_i  (n_ack_i)
);

`default_nettype wire

// ==== logic/dual_bridge_top.sv ====
`default_nettype none

module dual_bridge_top (
    input  wire logic                     clk,
    input  wire logic                     rst,

    // instruction port, wide side
    input  wire logic                     i_cyc_i,
    input  wire logic                     i_stb_i,
    input  wire logic                     i_we_i,
    input  wire bridge_pkg::wide_addr_t   i_adr_i,
    input  wire bridge_pkg::wide_data_t   i_dat_i,
    input  wire bridge_pkg::wide_sel_t    i_sel_i,
    output bridge_pkg::wide_data_t        i_dat_o,
    output logic                          i_ack_o,
    // instruction port, narrow side
    output logic                          i_n_cyc_o,
    output logic                          i_n_stb_o,
    output logic                          i_n_we_o,
    output bridge_pkg::narrow_addr_t      i_n_addr_o,
    output bridge_pkg::narrow_data_t      i_n_dat_o,
    input  wire bridge_pkg::narrow_data_t i_n_dat_i,
    output bridge_pkg::narrow_sel_t       i_n_sel_o,
    input  wire logic                     i_n_ack_i,

    // data port, wide side
    input  wire logic                     d_cyc_i,
    input  wire logic                     d_stb_i,
    input  wire logic                     d_we_i,
    input  wire bridge_pkg::wide_addr_t   d_adr_i,
    input  wire bridge_pkg::wide_data_t   d_dat_i,
    input  wire bridge_pkg::wide_sel_t    d_sel_i,
    output bridge_pkg::wide_data_t        d_dat_o,
    output logic                          d_ack_o,
    // data port, narrow side
    output logic                          d_n_cyc_o,
    output logic                          d_n_stb_o,
    output logic                          d_n_we_o,
    output bridge_pkg::narrow_addr_t      d_n_addr_o,
    output bridge_pkg::narrow_data_t      d_n_dat_o,
    input  wire bridge_pkg::narrow_data_t d_n_dat_i,
    output bridge_pkg::narrow_sel_t       d_n_sel_o,
    input  wire logic                     d_n_ack_i
);

    // instruction fetch bridge
    wb64_to_wb32_bridge u_bridge_i (
        .clk      (clk),
        .rst      (rst),
        .cyc_i    (i_cyc_i),
        .stb_i    (i_stb_i),
        .we_i     (i_we_i),
        .adr_i    (i_adr_i),
        .dat_i    (i_dat_i),
        .sel_i    (i_sel_i),
        .dat_o    (i_dat_o),
        .ack_o    (i_ack_o),
        .n_cyc_o  (i_n_cyc_o),
        .n_stb_o  (i_n_stb_o),
        .n_we_o   (i_n_we_o),
        .n_addr_o (i_n_addr_o),
        .n_dat_o  (i_n_dat_o),
        .n_dat_i  (i_n_dat_i),
        .n_sel_o  (i_n_sel_o),
        .n_ack_i  (i_n_ack_i)
    );

    // load/store bridge
    wb64_to_wb32_bridge u_bridge_d (
        .clk      (clk),
        .rst      (rst),
        .cyc_i    (d_cyc_i),
        .stb_i    (d_stb_i),
        .we_i     (d_we_i),
        .adr_i    (d_adr_i),
        .dat_i    (d_dat_i),
        .sel_i    (d_sel_i),
        .dat_o    (d_dat_o),
        .ack_o    (d_ack_o),
        .n_cyc_o  (d_n_cyc_o),
        .n_stb_o  (d_n_stb_o),
        .n_we_o   (d_n_we_o),
        .n_addr_o (d_n_addr_o),
        .n_dat_o  (d_n_dat_o),
        .n_dat_i  (d_n_dat_i),
        .n_sel_o  (d_n_sel_o),
        .n_ack_i  (d_n_ack_i)
    );

endmodule

`default_nettype wire

// ==== logic/wb64_to_wb32_bridge.sv ====
`default_nettype none

module wb64_to_wb32_bridge (
    input  wire logic                     clk,
    input  wire logic                     rst,

    // wide side, cpu
    input  wire logic                     cyc_i,
    input  wire logic                     stb_i,
    input  wire logic                     we_i,
    input  wire bridge_pkg::wide_addr_t   adr_i,
    input  wire bridge_pkg::wide_data_t   dat_i,
    input  wire bridge_pkg::wide_sel_t    sel_i,
    output bridge_pkg::wide_data_t        dat_o,
    output logic                          ack_o,

    // narrow side, memory
    output logic                          n_cyc_o,
    output logic                          n_stb_o,
    output logic                          n_we_o,
    output bridge_pkg::narrow_addr_t      n_addr_o,
    output bridge_pkg::narrow_data_t      n_dat_o,
    input  wire bridge_pkg::narrow_data_t n_dat_i,
    output bridge_pkg::narrow_sel_t       n_sel_o,
    input  wire logic                     n_ack_i
);

    beat_req_if  u_plan_if ();
    wb_narrow_if u_nbus_if ();

    logic                     beat_done;
    logic                     beat_high;
    bridge_pkg::narrow_data_t beat_rdata;
    logic                     plan_start;
    logic                     resp_go;

    req_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .cyc_i       (cyc_i),
        .stb_i       (stb_i),
        .we_i        (we_i),
        .adr_i       (adr_i),
        .dat_i       (dat_i),
        .sel_i       (sel_i),
        .resp_done_i (ack_o),     // unblock after the wide ack
        .plan        (u_plan_if.capture_mp)
    );

    beat_sequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .plan         (u_plan_if.seq_mp),
        .nbus         (u_nbus_if.master_mp),
        .beat_done_o  (beat_done),
        .beat_high_o  (beat_high),
        .beat_rdata_o (beat_rdata),
        .plan_start_o (plan_start),
        .resp_go_o    (resp_go)
    );

    resp_assemble u_assemble (
        .clk          (clk),
        .rst          (rst),
        .plan_start_i (plan_start),
        .beat_done_i  (beat_done),
        .beat_high_i  (beat_high),
        .beat_rdata_i (beat_rdata),
        .resp_go_i    (resp_go),
        .ack_o        (ack_o),
        .dat_o        (dat_o)
    );

    // narrow interface out to plain ports
    assign n_cyc_o         = u_nbus_if.cyc;
    assign n_stb_o         = u_nbus_if.stb;
    assign n_we_o          = u_nbus_if.we;
    assign n_addr_o        = u_nbus_if.addr;
    assign n_dat_o         = u_nbus_if.dat_w;
    assign n_sel_o         = u_nbus_if.sel;
    assign u_nbus_if.dat_r = n_dat_i;
    assign u_nbus_if.ack   = n_ack_i;

endmodule

`default_nettype wire

// ==== logic/resp_assemble.sv ====
`default_nettype none
`include "bridge_cfg.svh"

module resp_assemble (
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     plan_start_i,
    input  wire logic                     beat_done_i,
    input  wire logic                     beat_high_i,
    input  wire bridge_pkg::narrow_data_t beat_rdata_i,
    input  wire logic                     resp_go_i,

    output logic                          ack_o,
    output bridge_pkg::wide_data_t        dat_o
);

    bridge_pkg::wide_data_t buf_q; // read word under construction
    logic                   ack_q;

    // ack lands in the RESPOND cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= resp_go_i;
        end
    end

    always_ff @(posedge clk) begin
        if (plan_start_i) begin
            buf_q <= '0; // skipped halves and writes read back zero
        end else if (beat_done_i) begin
            if (beat_high_i) begin
                buf_q[`BR_WIDE_DATA_W-1:`BR_NARROW_DATA_W] <= beat_rdata_i;
            end else begin
                buf_q[`BR_NARROW_DATA_W-1:0] <= beat_rdata_i;
            end
        end
    end

    assign ack_o = ack_q;
    assign dat_o = buf_q;

endmodule

`default_nettype wire

// ==== logic/beat_sequencer.sv ====
`default_nettype none
`include "bridge_cfg.svh"

module beat_sequencer (
    input  wire logic                 clk,
    input  wire logic                 rst,

    beat_req_if.seq_mp                plan,
    wb_narrow_if.master_mp            nbus,

    output logic                      beat_done_o,  // read beat completed
    output logic                      beat_high_o,  // it was the high half
    output bridge_pkg::narrow_data_t  beat_rdata_o,
    output logic                      plan_start_o, // clears the assembler
    output logic                      resp_go_o     // all beats finished
);

    bridge_pkg::beat_state_e state_q;
    bridge_pkg::beat_state_e state_d;
    logic                    low_live;
    logic                    high_live;

    // a half with no selects is skipped
    assign low_live  = |plan.low_sel;
    assign high_live = |plan.high_sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= bridge_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d         = state_q;
        plan.plan_taken = 1'b0;
        resp_go_o       = 1'b0;
        beat_done_o     = 1'b0;
        nbus.cyc        = 1'b0;
        nbus.stb        = 1'b0;
        nbus.we         = 1'b0;
        nbus.addr       = '0;
        nbus.dat_w      = '0;
        nbus.sel        = '0;

        case (state_q)
            bridge_pkg::IDLE: begin
                if (plan.plan_valid) begin
                    plan.plan_taken = 1'b1;
                    if (low_live) begin
                        state_d = bridge_pkg::BEAT_LOW;
                    end else if (high_live) begin
                        state_d = bridge_pkg::BEAT_HIGH;
                    end else begin
                        state_d   = bridge_pkg::RESPOND; // nothing to move
                        resp_go_o = 1'b1;
                    end
                end
            end

            bridge_pkg::BEAT_LOW: begin
                nbus.cyc   = 1'b1;
                nbus.stb   = 1'b1;
                nbus.we    = plan.we;
                nbus.addr  = plan.base_addr;
                nbus.dat_w = plan.low_data;
                nbus.sel   = plan.low_sel;
                if (nbus.ack) begin
                    beat_done_o = !plan.we;
                    if (high_live) begin
                        state_d = bridge_pkg::BEAT_HIGH;
                    end else begin
                        state_d   = bridge_pkg::RESPOND;
                        resp_go_o = 1'b1;
                    end
                end
            end

            bridge_pkg::BEAT_HIGH: begin
                nbus.cyc   = 1'b1;
                nbus.stb   = 1'b1;
                nbus.we    = plan.we;
                nbus.addr  = plan.base_addr
                             + bridge_pkg::narrow_addr_t'(`BR_HIGH_BEAT_OFS);
                nbus.dat_w = plan.high_data;
                nbus.sel   = plan.high_sel;
                if (nbus.ack) begin
                    beat_done_o = !plan.we;
                    state_d     = bridge_pkg::RESPOND;
                    resp_go_o   = 1'b1;
                end
            end

            default: begin
                state_d = bridge_pkg::IDLE; // wide ack goes out this cycle
            end
        endcase
    end

    assign beat_high_o  = (state_q == bridge_pkg::BEAT_HIGH);
    assign beat_rdata_o = nbus.dat_r;
    assign plan_start_o = plan.plan_taken;

endmodule

`default_nettype wire

// ==== logic/req_capture.sv ====
`default_nettype none
`include "bridge_cfg.svh"

module req_capture (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire logic                   cyc_i,
    input  wire logic                   stb_i,
    input  wire logic                   we_i,
    input  wire bridge_pkg::wide_addr_t adr_i,
    input  wire bridge_pkg::wide_data_t dat_i,
    input  wire bridge_pkg::wide_sel_t  sel_i,
    input  wire logic                   resp_done_i, // wide ack of this request

    beat_req_if.capture_mp              plan
);

    logic busy_q;     // request in flight, no new accept
    logic plan_vld_q;
    logic accept;

    assign accept = cyc_i && stb_i && !busy_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q     <= 1'b0;
            plan_vld_q <= 1'b0;
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
            end else if (resp_done_i) begin
                busy_q <= 1'b0;
            end

            if (accept) begin
                plan_vld_q <= 1'b1;
            end else if (plan.plan_taken) begin
                plan_vld_q <= 1'b0;
            end
        end
    end

    // payload, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            plan.we        <= we_i;
            plan.base_addr <= {adr_i, {`BR_IDX_SHIFT{1'b0}}}; // index x 8
            plan.low_sel   <= sel_i[`BR_NARROW_SEL_W-1:0];
            plan.high_sel  <= sel_i[`BR_WIDE_SEL_W-1:`BR_NARROW_SEL_W];
            plan.low_data  <= dat_i[`BR_NARROW_DATA_W-1:0];
            plan.high_data <= dat_i[`BR_WIDE_DATA_W-1:`BR_NARROW_DATA_W];
        end
    end

    assign plan.plan_valid = plan_vld_q;

endmodule

`default_nettype wire

// ==== logic/bridge_ifs.sv ====
`default_nettype none

// narrow 32-bit classic wishbone link
interface wb_narrow_if;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    bridge_pkg::narrow_addr_t addr;
    bridge_pkg::narrow_data_t dat_w;
    bridge_pkg::narrow_data_t dat_r;
    bridge_pkg::narrow_sel_t  sel;
    logic                     ack;

    modport master_mp (output cyc, stb, we, addr, dat_w, sel, input dat_r, ack);
    modport port_mp   (input cyc, stb, we, addr, dat_w, sel, output dat_r, ack);
endinterface

// decoded request handed from capture to the sequencer
interface beat_req_if;
    logic                     plan_valid;
    logic                     we;
    bridge_pkg::narrow_addr_t base_addr;
    bridge_pkg::narrow_sel_t  low_sel;
    bridge_pkg::narrow_sel_t  high_sel;
    bridge_pkg::narrow_data_t low_data;
    bridge_pkg::narrow_data_t high_data;
    logic                     plan_taken;

    modport capture_mp (output plan_valid, we, base_addr, low_sel, high_sel,
                        low_data, high_data, input plan_taken);
    modport seq_mp     (input plan_valid, we, base_addr, low_sel, high_sel,
                        low_data, high_data, output plan_taken);
endinterface

`default_nettype wire

// ==== logic/bridge_pkg.sv ====
`default_nettype none
`include "bridge_cfg.svh"

package bridge_pkg;

    // wide (cpu) side
    typedef logic [`BR_WIDE_ADDR_W-1:0]   wide_addr_t;  // 64-bit word index
    typedef logic [`BR_WIDE_DATA_W-1:0]   wide_data_t;
    typedef logic [`BR_WIDE_SEL_W-1:0]    wide_sel_t;

    // narrow (memory) side
    typedef logic [`BR_NARROW_ADDR_W-1:0] narrow_addr_t; // byte address
    typedef logic [`BR_NARROW_DATA_W-1:0] narrow_data_t;
    typedef logic [`BR_NARROW_SEL_W-1:0]  narrow_sel_t;

    // beat sequencer states
    typedef enum logic [1:0] {
        IDLE,       // waiting for a beat plan
        BEAT_LOW,   // low word at base address
        BEAT_HIGH,  // high word at base + 4
        RESPOND     // wide ack cycle
    } beat_state_e;

endpackage

`default_nettype wire

// ==== logic/bridge_cfg.svh ====
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// wide side, one 64-bit word per address index
`define BR_WIDE_ADDR_W   29
`define BR_WIDE_DATA_W   64

// narrow side is byte addressed
`define BR_NARROW_DATA_W 32
`define BR_NARROW_ADDR_W 32

// one select bit per byte lane
`define BR_WIDE_SEL_W    (`BR_WIDE_DATA_W / 8)
`define BR_NARROW_SEL_W  (`BR_NARROW_DATA_W / 8)

// word index to byte address, and byte offset of the high beat
`define BR_IDX_SHIFT     3
`define BR_HIGH_BEAT_OFS 4

`endif
